/* hdl/lsu_defines.svh */
////////////////////////////////////////////////////////////
// load/store unit build constants
// data width, memory word address width and queue depth
////////////////////////////////////////////////////////////

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// width of one data word and of the register file values
`define LSU_XLEN 32

// word address width on the data-memory bus
`define LSU_ADDR_W 16

// number of decoded accesses the queue can hold
`define LSU_FIFO_DEPTH 4

`endif

/* hdl/lsu_pkg.sv */
////////////////////////////////////////////////////////////
// load/store unit shared types
// instruction fields, decoded access and bus bundles
////////////////////////////////////////////////////////////

`include "lsu_defines.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]   xlen_t;
    typedef logic [`LSU_XLEN/8-1:0] strb_t;
    typedef logic [4:0]             reg_addr_t;
    typedef logic [`LSU_ADDR_W-1:0] word_addr_t;

    // major opcodes handled here, anything else is dropped
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } lsu_opcode_e;

    // funct3 access size, stores only use the signed codes
    typedef enum logic [2:0] {
        WIDTH_B  = 3'd0,
        WIDTH_H  = 3'd1,
        WIDTH_W  = 3'd2,
        WIDTH_BU = 3'd4,
        WIDTH_HU = 3'd5
    } lsu_width_e;

    ////////////////////////////////////////////////////////////
    // instruction side

    // R-type view, immediates are rebuilt from these fields
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } rv_inst_t;

    // instruction with its operand values already read
    typedef struct packed {
        rv_inst_t inst;
        xlen_t    rs1_val;
        xlen_t    rs2_val;
    } lsu_op_t;

    ////////////////////////////////////////////////////////////
    // queued access and bus bundles

    // one access as the decoder hands it to the sequencer
    typedef struct packed {
        logic       is_store;
        lsu_width_e width;
        word_addr_t word_addr;
        logic [1:0] offset;
        // store data already rotated to its byte lanes
        xlen_t      wdata;
        strb_t      strb0;
        strb_t      strb1;
        logic       two_phase;
        reg_addr_t  rd;
    } lsu_access_t;

    typedef struct packed {
        logic       wr;
        word_addr_t addr;
        xlen_t      wdata;
        strb_t      strb;
    } mem_req_t;

    typedef struct packed {
        reg_addr_t addr;
        xlen_t     value;
    } rd_write_t;

endpackage

/* hdl/lsu_request_decoder.sv */
////////////////////////////////////////////////////////////
// load/store request decoder
// builds address, lane-aligned data and strobes of an access
////////////////////////////////////////////////////////////

`include "lsu_defines.svh"

module lsu_request_decoder (
    input  lsu_pkg::lsu_op_t     op,
    input  logic                 op_en,
    input  logic                 full,
    output logic                 push,
    output lsu_pkg::lsu_access_t access
);

    import lsu_pkg::*;

    localparam int STRB_W = `LSU_XLEN / 8;

    logic                      is_load;
    logic                      is_store;
    lsu_width_e                width;
    xlen_t                     imm;
    xlen_t                     byte_addr;
    logic [1:0]                offset;
    strb_t                     mask;
    logic [2*STRB_W-1:0]       strb_pair;
    logic [2*`LSU_XLEN-1:0]    wdata_pair;

    ////////////////////////////////////////////////////////////
    // address generation

    assign is_load  = (op.inst.opcode == OP_LOAD);
    assign is_store = (op.inst.opcode == OP_STORE);
    assign width    = lsu_width_e'(op.inst.funct3);

    // I-type keeps imm[4:0] in the rs2 slot, S-type in the rd slot
    always_comb begin
        if (is_store) begin
            imm = {{(`LSU_XLEN-12){op.inst.funct7[6]}}, op.inst.funct7, op.inst.rd};
        end else begin
            imm = {{(`LSU_XLEN-12){op.inst.funct7[6]}}, op.inst.funct7, op.inst.rs2};
        end
    end

    assign byte_addr = op.rs1_val + imm;
    assign offset    = byte_addr[1:0];

    ////////////////////////////////////////////////////////////
    // lane alignment

    // bytes touched before any shifting
    always_comb begin
        case (width)
            WIDTH_B, WIDTH_BU: mask = strb_t'(1);
            WIDTH_H, WIDTH_HU: mask = strb_t'(3);
            default:           mask = '1;
        endcase
    end

    // upper half holds the lanes that spill into the next word
    assign strb_pair  = {{STRB_W{1'b0}}, mask} << offset;

    // upper half of the doubled word shifted left is the rotation
    assign wdata_pair = {op.rs2_val, op.rs2_val} << {offset, 3'b000};

    always_comb begin
        access.is_store  = is_store;
        access.width     = width;
        access.word_addr = byte_addr[`LSU_ADDR_W+1:2];
        access.offset    = offset;
        access.wdata     = wdata_pair[2*`LSU_XLEN-1:`LSU_XLEN];
        access.strb0     = strb_pair[STRB_W-1:0];
        access.strb1     = strb_pair[2*STRB_W-1:STRB_W];
        // half at offset 3 or word off alignment crosses a word
        access.two_phase = |strb_pair[2*STRB_W-1:STRB_W];
        access.rd        = op.inst.rd;
    end

    // other opcodes are taken but never reach the queue
    assign push = op_en && !full && (is_load || is_store);

endmodule

/* hdl/lsu_access_fifo.sv */
////////////////////////////////////////////////////////////
// access queue between decoder and memory sequencer
////////////////////////////////////////////////////////////

`include "lsu_defines.svh"

module lsu_access_fifo (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 push,
    input  lsu_pkg::lsu_access_t wr_entry,
    input  logic                 pop,
    output logic                 full,
    output logic                 not_empty,
    output lsu_pkg::lsu_access_t rd_entry
);

    import lsu_pkg::*;

    localparam int DEPTH = `LSU_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    lsu_access_t      slots [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap explicitly so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;

    // head entry is read straight from storage
    assign rd_entry  = slots[rd_ptr];

    always_ff @(posedge aclk) begin
        if (do_push) begin
            slots[wr_ptr] <= wr_entry;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // simultaneous push and pop keep the level
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hdl/lsu_load_formatter.sv */
////////////////////////////////////////////////////////////
// load formatter
// picks the addressed bytes and extends them to a full word
////////////////////////////////////////////////////////////

`include "lsu_defines.svh"

module lsu_load_formatter (
    input  lsu_pkg::lsu_width_e width,
    input  logic [1:0]          offset,
    input  logic                two_phase,
    input  lsu_pkg::xlen_t      first_word,
    input  lsu_pkg::xlen_t      last_word,
    output lsu_pkg::xlen_t      value
);

    import lsu_pkg::*;

    logic [2*`LSU_XLEN-1:0] pair;
    logic [2*`LSU_XLEN-1:0] shifted;
    xlen_t                  aligned;

    // split loads put the later word above the earlier one
    assign pair    = two_phase ? {last_word, first_word} : {{`LSU_XLEN{1'b0}}, last_word};
    assign shifted = pair >> {offset, 3'b000};
    assign aligned = shifted[`LSU_XLEN-1:0];

    always_comb begin
        case (width)
            WIDTH_B:  value = {{(`LSU_XLEN-8){aligned[7]}}, aligned[7:0]};
            WIDTH_H:  value = {{(`LSU_XLEN-16){aligned[15]}}, aligned[15:0]};
            WIDTH_BU: value = {{(`LSU_XLEN-8){1'b0}}, aligned[7:0]};
            WIDTH_HU: value = {{(`LSU_XLEN-16){1'b0}}, aligned[15:0]};
            // word load and any unused code
            default:  value = aligned;
        endcase
    end

endmodule

/* hdl/lsu_memory_sequencer.sv */
////////////////////////////////////////////////////////////
// memory sequencer
// runs queued accesses in one or two bus phases, writes rd
////////////////////////////////////////////////////////////

module lsu_memory_sequencer (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 not_empty,
    input  lsu_pkg::lsu_access_t entry,
    input  lsu_pkg::xlen_t       mem_rdata,
    input  logic                 mem_ready,
    output logic                 pop,
    output logic                 mem_en,
    output lsu_pkg::mem_req_t    mem_req,
    output logic                 rd_wr,
    output lsu_pkg::rd_write_t   rd
);

    import lsu_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PHASE0,
        ST_PHASE1
    } seq_state_e;

    seq_state_e  state;
    lsu_access_t cur;
    xlen_t       first_word;
    xlen_t       load_value;
    logic        in_phase1;
    logic        phase0_split_done;
    logic        final_done;

    ////////////////////////////////////////////////////////////
    // bus request

    // take the head as soon as the bus is free
    assign pop       = (state == ST_IDLE) && not_empty;
    assign mem_en    = (state != ST_IDLE);
    assign in_phase1 = (state == ST_PHASE1);

    // second phase hits the following word with the spilled lanes
    always_comb begin
        mem_req.wr    = mem_en && cur.is_store;
        mem_req.addr  = cur.word_addr + word_addr_t'(in_phase1);
        mem_req.wdata = cur.wdata;
        mem_req.strb  = in_phase1 ? cur.strb1 : cur.strb0;
    end

    assign phase0_split_done = (state == ST_PHASE0) && mem_ready && cur.two_phase;
    assign final_done        = mem_ready &&
                               ((state == ST_PHASE0 && !cur.two_phase) || in_phase1);

    ////////////////////////////////////////////////////////////
    // phase control

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= ST_IDLE;
            rd_wr <= 1'b0;
        end else begin
            // one cycle pulse per completed load
            rd_wr <= final_done && !cur.is_store;
            case (state)
                ST_IDLE: begin
                    if (not_empty) begin
                        state <= ST_PHASE0;
                    end
                end
                ST_PHASE0: begin
                    if (mem_ready) begin
                        state <= cur.two_phase ? ST_PHASE1 : ST_IDLE;
                    end
                end
                ST_PHASE1: begin
                    if (mem_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // access and load data holding

    always_ff @(posedge aclk) begin
        if (pop) begin
            cur <= entry;
        end
        // low word of a split load waits for its partner
        if (phase0_split_done && !cur.is_store) begin
            first_word <= mem_rdata;
        end
        if (final_done && !cur.is_store) begin
            rd.addr  <= cur.rd;
            rd.value <= load_value;
        end
    end

    // last word comes straight from the bus on the final edge
    lsu_load_formatter u_formatter (
        .width      (cur.width),
        .offset     (cur.offset),
        .two_phase  (cur.two_phase),
        .first_word (first_word),
        .last_word  (mem_rdata),
        .value      (load_value)
    );

endmodule

/* hdl/lsu_top.sv */
////////////////////////////////////////////////////////////
// load/store unit top
// decoder, access queue and memory sequencer in a chain
////////////////////////////////////////////////////////////

module lsu_top (
    input  logic               aclk,
    input  logic               aresetn,
    input  lsu_pkg::lsu_op_t   op,
    input  logic               op_en,
    output logic               op_ready,
    output logic               mem_en,
    output lsu_pkg::mem_req_t  mem_req,
    input  lsu_pkg::xlen_t     mem_rdata,
    input  logic               mem_ready,
    output logic               rd_wr,
    output lsu_pkg::rd_write_t rd
);

    import lsu_pkg::*;

    logic        push;
    logic        pop;
    logic        full;
    logic        not_empty;
    lsu_access_t dec_access;
    lsu_access_t head_access;

    // queue space is the only condition on taking an op
    assign op_ready = !full;

    lsu_request_decoder u_decoder (
        .op     (op),
        .op_en  (op_en),
        .full   (full),
        .push   (push),
        .access (dec_access)
    );

    lsu_access_fifo u_fifo (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .push      (push),
        .wr_entry  (dec_access),
        .pop       (pop),
        .full      (full),
        .not_empty (not_empty),
        .rd_entry  (head_access)
    );

    lsu_memory_sequencer u_sequencer (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .not_empty (not_empty),
        .entry     (head_access),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .pop       (pop),
        .mem_en    (mem_en),
        .mem_req   (mem_req),
        .rd_wr     (rd_wr),
        .rd        (rd)
    );

endmodule

/* verification/lsu_chk.sv */
////////////////////////////////////////////////////////////
// memory sequencer protocol checks
// bus request hold, rd write pulse and reset idle
////////////////////////////////////////////////////////////

module lsu_chk (
    input logic              aclk,
    input logic              aresetn,
    input logic              mem_en,
    input lsu_pkg::mem_req_t mem_req,
    input logic              mem_ready,
    input logic              rd_wr
);

    // a stalled request stays on the bus unchanged
    property req_held;
        @(posedge aclk) disable iff (!aresetn)
        (mem_en && !mem_ready) |=> (mem_en && $stable(mem_req));
    endproperty

    // one pulse per completed load
    property rd_single_pulse;
        @(posedge aclk) disable iff (!aresetn)
        rd_wr |=> !rd_wr;
    endproperty

    property idle_in_reset;
        @(posedge aclk) !aresetn |-> !mem_en;
    endproperty

    a_req_held: assert property (req_held)
        else $error("memory request changed while mem_ready was low");

    a_rd_single_pulse: assert property (rd_single_pulse)
        else $error("rd_wr high for two cycles");

    a_idle_in_reset: assert property (idle_in_reset)
        else $error("mem_en high during reset");

endmodule

bind lsu_memory_sequencer lsu_chk u_chk (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .mem_en    (mem_en),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .rd_wr     (rd_wr)
);

/* verification/lsu_tb.sv */
////////////////////////////////////////////////////////////
// load/store unit testbench
// directed tests against a stalling memory and a byte shadow
////////////////////////////////////////////////////////////

`include "lsu_defines.svh"

module lsu_tb;

    import lsu_pkg::*;

    // about 80 ops at worst 12 cycles each, plus reset and queueing
    localparam int MAX_CYCLES = 3000;
    localparam int MEM_WORDS  = 1024;

    logic       aclk;
    logic       aresetn;
    lsu_op_t    op;
    logic       op_en;
    logic       op_ready;
    logic       mem_en;
    mem_req_t   mem_req;
    xlen_t      mem_rdata;
    logic       mem_ready;
    logic       rd_wr;
    rd_write_t  rd;

    xlen_t      mem [MEM_WORDS];
    // expected memory image, one entry per byte
    logic [7:0] shadow [4*MEM_WORDS];
    word_addr_t phase_q [$];
    rd_write_t  load_q [$];
    mem_req_t   taken_req;
    logic       hold_ready;
    int         stall;
    int         cycles = 0;
    int         checks;
    int         errors;
    int         test_errors;

    lsu_top UUT (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .op        (op),
        .op_en     (op_en),
        .op_ready  (op_ready),
        .mem_en    (mem_en),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .rd_wr     (rd_wr),
        .rd        (rd)
    );

    always #2 aclk = ~aclk;

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // compare tasks

    task automatic flag_error(input string what);
        errors++;
        $display("ERROR %0t %s", $time, what);
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_rd_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bus_addr(input string name, input word_addr_t got,
                                  input word_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_mem_word(input word_addr_t index, input xlen_t exp);
        check_word($sformatf("mem[%h]", index), mem[index[9:0]], exp);
    endtask

    ////////////////////////////////////////////////////////////
    // memory model and rd monitor

    // every word differs, so a wrong address shows up in the data
    function automatic xlen_t fill_word(input int idx);
        return (xlen_t'(idx) * 32'h0101_0107) ^ 32'h5A3C_96E1;
    endfunction

    function automatic xlen_t shadow_word(input word_addr_t a);
        xlen_t w;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = shadow[4*a + b];
        end
        return w;
    endfunction

    task automatic complete_phase();
        word_addr_t exp_addr;
        int         idx;
        idx = taken_req.addr[9:0];
        if (phase_q.size() == 0) begin
            flag_error("memory phase completed with no access pending");
        end else begin
            exp_addr = phase_q.pop_front();
            check_bus_addr("mem_req.addr", taken_req.addr, exp_addr);
        end
        if (taken_req.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (taken_req.strb[b]) begin
                    mem[idx][8*b +: 8] = taken_req.wdata[8*b +: 8];
                end
            end
        end
    endtask

    always @(negedge aclk) begin
        // ready high here means the last rising edge ended that phase
        if (mem_ready) begin
            complete_phase();
            stall = $urandom_range(3, 0);
        end
        if (aresetn && mem_en && phase_q.size() == 0) begin
            flag_error("memory request with no access pending");
        end
        if (aresetn && mem_en && !hold_ready && stall == 0) begin
            taken_req = mem_req;
            mem_rdata = mem[mem_req.addr[9:0]];
            mem_ready = 1'b1;
        end else begin
            mem_ready = 1'b0;
            if (mem_en && !hold_ready && stall > 0) begin
                stall--;
            end
        end
    end

    always @(negedge aclk) begin
        rd_write_t e;
        if (aresetn && rd_wr) begin
            if (load_q.size() == 0) begin
                flag_error("rd written with no load pending");
            end else begin
                e = load_q.pop_front();
                check_rd_addr("rd.addr", rd.addr, e.addr);
                check_word("rd.value", rd.value, e.value);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // op issue with expected results

    function automatic int width_bytes(input lsu_width_e w);
        case (w)
            WIDTH_B, WIDTH_BU: return 1;
            WIDTH_H, WIDTH_HU: return 2;
            default:           return 4;
        endcase
    endfunction

    // one phase per touched word, in ascending order
    task automatic expect_phases(input int addr, input int n);
        phase_q.push_back(word_addr_t'(addr >> 2));
        if (((addr + n - 1) >> 2) != (addr >> 2)) begin
            phase_q.push_back(word_addr_t'((addr >> 2) + 1));
        end
    endtask

    // called on a falling edge, returns on the one after acceptance
    task automatic issue_op(input lsu_op_t o);
        op    = o;
        op_en = 1'b1;
        while (!op_ready) begin
            @(negedge aclk);
        end
        @(negedge aclk);
        op_en = 1'b0;
    endtask

    task automatic load_access(input lsu_width_e w, input reg_addr_t rd_idx, input int addr,
                               input int imm);
        lsu_op_t   o;
        rd_write_t e;
        int        n;
        n       = width_bytes(w);
        e.addr  = rd_idx;
        e.value = '0;
        // little-endian bytes from the byte address upward
        for (int i = 0; i < n; i++) begin
            e.value[8*i +: 8] = shadow[addr + i];
        end
        if (w == WIDTH_B || w == WIDTH_H) begin
            for (int i = 8*n; i < 32; i++) begin
                e.value[i] = e.value[8*n-1];
            end
        end
        load_q.push_back(e);
        expect_phases(addr, n);
        o              = '0;
        o.inst.opcode  = OP_LOAD;
        o.inst.funct3  = w;
        o.inst.rd      = rd_idx;
        o.inst.rs1     = 5'd1;
        // I-type immediate sits in funct7 and the rs2 field
        o.inst.funct7  = imm[11:5];
        o.inst.rs2     = imm[4:0];
        o.rs1_val      = xlen_t'(addr - imm);
        issue_op(o);
    endtask

    task automatic store_access(input lsu_width_e w, input int addr, input int imm,
                                input xlen_t data);
        lsu_op_t o;
        int      n;
        n = width_bytes(w);
        for (int i = 0; i < n; i++) begin
            shadow[addr + i] = data[8*i +: 8];
        end
        expect_phases(addr, n);
        o             = '0;
        o.inst.opcode = OP_STORE;
        o.inst.funct3 = w;
        o.inst.rs1    = 5'd1;
        o.inst.rs2    = 5'd2;
        // S-type immediate sits in funct7 and the rd field
        o.inst.funct7 = imm[11:5];
        o.inst.rd     = imm[4:0];
        o.rs1_val     = xlen_t'(addr - imm);
        o.rs2_val     = data;
        issue_op(o);
    endtask

    task automatic non_memory_op(input logic [6:0] opcode);
        lsu_op_t o;
        o             = '0;
        o.inst.opcode = opcode;
        o.inst.rd     = 5'd31;
        o.rs1_val     = 32'h0000_0100;
        issue_op(o);
    endtask

    task automatic drain();
        while (phase_q.size() != 0 || load_q.size() != 0) begin
            @(negedge aclk);
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d errors", name, errors - test_errors);
    endtask

    ////////////////////////////////////////////////////////////
    // tests

    task automatic reset_and_word();
        test_errors = errors;
        if (mem_en !== 1'b0 || rd_wr !== 1'b0) begin
            flag_error("mem_en or rd_wr high after reset");
        end
        if (op_ready !== 1'b1) begin
            flag_error("op_ready low after reset");
        end
        store_access(WIDTH_W, 'h100, 12, 32'hCAFE_F00D);
        load_access(WIDTH_W, 5'd7, 'h100, -20);
        drain();
        end_test("reset and aligned word");
    endtask

    task automatic sub_word_access();
        test_errors = errors;
        // low bytes and halves carry a set sign bit
        for (int off = 0; off < 4; off++) begin
            store_access(WIDTH_B, 'h200 + off, off * 3, 32'h1234_5680 + 32'h11 * off);
        end
        for (int off = 0; off < 3; off++) begin
            store_access(WIDTH_H, 'h210 + off, -off, 32'h1357_8642 + off);
        end
        drain();
        for (int a = 'h80; a <= 'h85; a++) begin
            check_mem_word(word_addr_t'(a), shadow_word(word_addr_t'(a)));
        end
        for (int off = 0; off < 4; off++) begin
            load_access(WIDTH_B, reg_addr_t'(8 + off), 'h200 + off, 4);
            load_access(WIDTH_BU, reg_addr_t'(12 + off), 'h200 + off, -4);
        end
        for (int off = 0; off < 3; off++) begin
            load_access(WIDTH_H, reg_addr_t'(16 + off), 'h210 + off, 0);
            load_access(WIDTH_HU, reg_addr_t'(20 + off), 'h210 + off, 100);
        end
        drain();
        end_test("sub-word access");
    endtask

    task automatic split_access();
        test_errors = errors;
        for (int off = 1; off < 4; off++) begin
            store_access(WIDTH_W, 'h300 + 16*off + off, -8, 32'hA1B2_C3D4 + off);
        end
        store_access(WIDTH_H, 'h343, 16, 32'h0000_9ABC);
        drain();
        for (int a = 'hC0; a <= 'hD1; a++) begin
            check_mem_word(word_addr_t'(a), shadow_word(word_addr_t'(a)));
        end
        for (int off = 1; off < 4; off++) begin
            load_access(WIDTH_W, reg_addr_t'(off), 'h300 + 16*off + off, 40);
        end
        load_access(WIDTH_H, 5'd4, 'h343, 0);
        // untouched fill data across a word boundary
        load_access(WIDTH_H, 5'd5, 'h357, -1);
        load_access(WIDTH_W, 5'd6, 'h362, 7);
        drain();
        end_test("split access");
    endtask

    task automatic non_memory_ops();
        test_errors = errors;
        non_memory_op(7'b0110011);
        non_memory_op(7'b0010011);
        non_memory_op(7'b1100011);
        load_access(WIDTH_W, 5'd9, 'h100, 0);
        drain();
        end_test("non-memory ops");
    endtask

    task automatic back_pressure();
        test_errors = errors;
        hold_ready = 1'b1;
        for (int i = 0; i <= `LSU_FIFO_DEPTH; i++) begin
            load_access(WIDTH_W, reg_addr_t'(10 + i), 'h400 + 4*i, 8*i);
        end
        if (op_ready !== 1'b0) begin
            flag_error("op_ready stayed high with the queue full");
        end
        hold_ready = 1'b0;
        drain();
        end_test("back-pressure");
    endtask

    task automatic random_mix();
        int addr;
        int imm;
        int sel;
        test_errors = errors;
        for (int i = 0; i < 40; i++) begin
            // narrow window so loads often hit stored bytes
            addr = $urandom_range('h67F, 'h600);
            imm  = int'($urandom_range(1023, 0)) - 512;
            if ($urandom_range(1, 0) == 1) begin
                sel = $urandom_range(2, 0);
                store_access(lsu_width_e'(sel), addr, imm, $urandom());
            end else begin
                sel = $urandom_range(4, 0);
                load_access(lsu_width_e'(sel + ((sel > 2) ? 1 : 0)),
                            reg_addr_t'($urandom_range(31, 1)), addr, imm);
            end
        end
        drain();
        for (int a = 'h180; a <= 'h1A0; a++) begin
            check_mem_word(word_addr_t'(a), shadow_word(word_addr_t'(a)));
        end
        end_test("random mix");
    endtask

    initial begin
        void'($urandom(49003));
        aclk       = 1'b0;
        aresetn    = 1'b0;
        op         = '0;
        op_en      = 1'b0;
        mem_ready  = 1'b0;
        mem_rdata  = '0;
        hold_ready = 1'b0;
        stall      = 0;
        checks     = 0;
        errors     = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(i);
            for (int b = 0; b < 4; b++) begin
                shadow[4*i + b] = mem[i][8*b +: 8];
            end
        end
        repeat (8) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        reset_and_word();
        sub_word_access();
        split_access();
        non_memory_ops();
        back_pressure();
        random_mix();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_request_decoder.sv
hdl/lsu_access_fifo.sv
hdl/lsu_load_formatter.sv
hdl/lsu_memory_sequencer.sv
hdl/lsu_top.sv
verification/lsu_chk.sv
verification/lsu_tb.sv
